// ==== compile.f ====
logic/tensor_mod_pkg.sv
logic/scalar_mod_core.sv
logic/vector_mod_unit.sv
logic/tensor_mod_ctrl.sv
logic/tensor_mod_top.sv
sim/tensor_mod_assert.sv
sim/tensor_mod_tb.sv

// ==== Makefile ====
# Verilator build and run for the tensor modulo testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tensor_mod_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# Exit status of the simulation binary is the test result
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tensor_mod_tb.sv ====
/*
  Testbench for the tensor modulo subsystem
  Seeded random tensors, queue reference model, compare tasks, watchdog
*/

`timescale 1ns/100ps
`default_nettype none

module tensor_mod_tb;

  localparam int DATA_SIZE    = 16;
  localparam int CONTROL_SIZE = 8;
  localparam int NUM_RANDOM   = 20;
  localparam int NUM_EDGE     = 6;
  // 6 x 6 tensor at most
  localparam int MAX_ELEMS    = 36;
  localparam int WATCHDOG_CYCLES =
    (NUM_RANDOM + NUM_EDGE) * MAX_ELEMS * (DATA_SIZE + 10) + 1000;

  logic                    CLK = 1'b0;
  logic                    RST;
  logic                    START;
  logic [CONTROL_SIZE-1:0] SIZE_I_IN;
  logic [CONTROL_SIZE-1:0] SIZE_J_IN;
  logic [DATA_SIZE-1:0]    MODULO_IN;
  logic [DATA_SIZE-1:0]    DATA_IN;
  logic                    DATA_IN_I_ENABLE;
  logic                    DATA_IN_J_ENABLE;
  logic                    READY;
  logic                    DATA_OUT_I_ENABLE;
  logic                    DATA_OUT_J_ENABLE;
  logic [DATA_SIZE-1:0]    DATA_OUT;

  integer seed = 32'h2067;

  // Expected results in input order, with row and tensor end flags
  logic [DATA_SIZE-1:0] exp_data[$];
  bit exp_row_end[$];
  bit exp_last[$];

  int pushed_count = 0;
  int result_count = 0;
  int row_count    = 0;
  int ready_count  = 0;

  tensor_mod_top #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_tensor_mod_top (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_I_IN        (SIZE_I_IN),
    .SIZE_J_IN        (SIZE_J_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_IN          (DATA_IN),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .READY            (READY),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .DATA_OUT         (DATA_OUT)
  );

  // 8 ns clock
  initial begin
    forever #4 CLK = ~CLK;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DATA_SIZE-1:0] got,
                            input logic [DATA_SIZE-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Modulus 0 leaves the element as it is
  function automatic logic [DATA_SIZE-1:0] expected_remainder(
    input logic [DATA_SIZE-1:0] elem, input logic [DATA_SIZE-1:0] modulus);
    if (modulus == '0) begin
      return elem;
    end
    return elem % modulus;
  endfunction

  // Random width first, so small moduli show up often
  function automatic logic [DATA_SIZE-1:0] random_modulus();
    int width;
    logic [31:0] mask;
    logic [DATA_SIZE-1:0] value;
    width = 1 + ($unsigned($random(seed)) % DATA_SIZE);
    mask  = (32'd1 << width) - 32'd1;
    value = DATA_SIZE'($random(seed)) & DATA_SIZE'(mask);
    if (value == '0) begin
      value = 1;
    end
    return value;
  endfunction

  function automatic logic [DATA_SIZE-1:0] random_element(input bit edge_mix);
    if (!edge_mix) begin
      return DATA_SIZE'($random(seed));
    end
    case ($unsigned($random(seed)) % 4)
      0:       return '0;
      1:       return '1;
      2:       return DATA_SIZE'($random(seed)) & DATA_SIZE'(8'hff);
      default: return DATA_SIZE'($random(seed));
    endcase
  endfunction

  // Outputs change on the rising edge, read them half a cycle later
  always @(negedge CLK) begin : output_monitor
    logic [DATA_SIZE-1:0] exp_val;
    bit row_end;
    bit last;
    if (RST) begin
      check_strobe("DATA_OUT_J_ENABLE", DATA_OUT_J_ENABLE, 1'b0);
      check_strobe("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE, 1'b0);
      check_strobe("READY", READY, 1'b0);
      check_data("DATA_OUT", DATA_OUT, '0);
    end else if (DATA_OUT_J_ENABLE) begin
      if (exp_data.size() == 0) begin
        report_failure("Result strobe seen with no element outstanding");
      end
      exp_val = exp_data.pop_front();
      row_end = exp_row_end.pop_front();
      last    = exp_last.pop_front();
      check_data("DATA_OUT", DATA_OUT, exp_val);
      check_strobe("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE, row_end);
      check_strobe("READY", READY, last);
      result_count++;
      if (DATA_OUT_I_ENABLE) row_count++;
      if (READY) ready_count++;
    end else begin
      check_strobe("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE, 1'b0);
      check_strobe("READY", READY, 1'b0);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic send_start(input int rows, input int cols,
                            input logic [DATA_SIZE-1:0] modulus);
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_I_IN <= CONTROL_SIZE'(rows);
    SIZE_J_IN <= CONTROL_SIZE'(cols);
    MODULO_IN <= modulus;
    @(posedge CLK);
    START     <= 1'b0;
    // Only the values latched at START may be used
    SIZE_I_IN <= CONTROL_SIZE'($random(seed));
    SIZE_J_IN <= CONTROL_SIZE'($random(seed));
    MODULO_IN <= DATA_SIZE'($random(seed));
  endtask

  // Enables and START while the core is still busy
  task automatic pulse_noise();
    int gap;
    gap = 1 + ($unsigned($random(seed)) % 8);
    repeat (gap) @(posedge CLK);
    DATA_IN          <= DATA_SIZE'($random(seed));
    DATA_IN_I_ENABLE <= 1'b1;
    DATA_IN_J_ENABLE <= 1'b1;
    START            <= 1'b1;
    @(posedge CLK);
    DATA_IN_I_ENABLE <= 1'b0;
    DATA_IN_J_ENABLE <= 1'b0;
    START            <= 1'b0;
  endtask

  task automatic send_element(input logic [DATA_SIZE-1:0] value, input bit first,
                              input bit noise);
    @(posedge CLK);
    DATA_IN <= value;
    if (first) begin
      DATA_IN_I_ENABLE <= 1'b1;
    end else begin
      DATA_IN_J_ENABLE <= 1'b1;
    end
    @(posedge CLK);
    DATA_IN_I_ENABLE <= 1'b0;
    DATA_IN_J_ENABLE <= 1'b0;
    DATA_IN          <= DATA_SIZE'($random(seed));
    if (noise) pulse_noise();
    // Host waits for the result strobe before the next element
    while (result_count < pushed_count) @(posedge CLK);
  endtask

  task automatic run_tensor(input int rows, input int cols,
                            input logic [DATA_SIZE-1:0] modulus,
                            input bit edge_mix, input bit noise);
    int rows_before;
    int ready_before;
    logic [DATA_SIZE-1:0] elem;
    rows_before  = row_count;
    ready_before = ready_count;
    send_start(rows, cols, modulus);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        elem = random_element(edge_mix);
        exp_data.push_back(expected_remainder(elem, modulus));
        exp_row_end.push_back(c == cols - 1);
        exp_last.push_back((r == rows - 1) && (c == cols - 1));
        pushed_count++;
        send_element(elem, c == 0, noise);
      end
    end
    check_count("DATA_OUT_I_ENABLE pulses", row_count - rows_before, rows);
    check_count("READY pulses", ready_count - ready_before, 1);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    report_failure($sformatf("Timeout, run still going after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin : main_sequence
    int rows;
    int cols;
    RST              = 1'b1;
    START            = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    MODULO_IN        = '0;
    DATA_IN          = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    // Idle after reset, the monitor keeps the strobes low
    repeat (10) begin
      @(negedge CLK);
      check_data("DATA_OUT", DATA_OUT, '0);
    end

    // Edge moduli and edge elements
    run_tensor(3, 4, '0, 1'b1, 1'b0);
    run_tensor(2, 5, DATA_SIZE'(1), 1'b1, 1'b0);
    run_tensor(2, 3, '1, 1'b1, 1'b0);
    run_tensor(4, 2, DATA_SIZE'(16'hf000), 1'b1, 1'b1);
    run_tensor(1, 1, random_modulus(), 1'b1, 1'b0);
    run_tensor(6, 6, DATA_SIZE'(3), 1'b1, 1'b1);

    // Back to back random tensors, noise on every other one
    for (int t = 0; t < NUM_RANDOM; t++) begin
      rows = 1 + ($unsigned($random(seed)) % 6);
      cols = 1 + ($unsigned($random(seed)) % 6);
      run_tensor(rows, cols, random_modulus(), 1'b0, t[0]);
    end

    // Long enough for a stray late result to reach the monitor
    repeat (DATA_SIZE + 10) @(posedge CLK);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tensor_mod_assert.sv ====
/*
  Concurrent checks on the top-level result strobes
  Bound into tensor_mod_top
*/

`timescale 1ns/100ps
`default_nettype none

module tensor_mod_assert
  import tensor_mod_pkg::*;
(
  input logic          CLK,
  input logic          RST,
  input logic          READY,
  input logic          DATA_OUT_I_ENABLE,
  input logic          DATA_OUT_J_ENABLE,
  input tensor_state_e ctrl_state
);

  ////////////////////
  // Strobe nesting
  ////////////////////

  // Tensor end is always a row end
  ready_with_row_end: assert property (
    @(posedge CLK) disable iff (RST) READY |-> DATA_OUT_I_ENABLE
  ) else $error("READY without DATA_OUT_I_ENABLE");

  // Row end is always a result
  row_end_with_result: assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE
  ) else $error("DATA_OUT_I_ENABLE without DATA_OUT_J_ENABLE");

  // Results only come back while the controller holds a tensor
  result_in_tensor: assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_J_ENABLE |-> (ctrl_state != tensor_idle)
  ) else $error("Result strobe while the controller is idle");

  ////////////////////
  // Reset and width
  ////////////////////

  quiet_in_reset: assert property (
    @(posedge CLK) RST |-> !(READY || DATA_OUT_I_ENABLE || DATA_OUT_J_ENABLE)
  ) else $error("Output strobe active during reset");

  // One element in flight, so strobes never stretch
  result_one_wide: assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_J_ENABLE |=> !DATA_OUT_J_ENABLE
  ) else $error("DATA_OUT_J_ENABLE wider than one cycle");

  row_end_one_wide: assert property (
    @(posedge CLK) disable iff (RST) DATA_OUT_I_ENABLE |=> !DATA_OUT_I_ENABLE
  ) else $error("DATA_OUT_I_ENABLE wider than one cycle");

  ready_one_wide: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else $error("READY wider than one cycle");

endmodule

bind tensor_mod_top tensor_mod_assert u_tensor_mod_assert (
  .CLK              (CLK),
  .RST              (RST),
  .READY            (READY),
  .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
  .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
  .ctrl_state       (u_tensor_mod_ctrl.state)
);

`default_nettype wire

// ==== logic/tensor_mod_top.sv ====
/*
  Tensor modulo top level
  Row controller and vector unit, output data register
*/

`timescale 1ns/100ps
`default_nettype none

module tensor_mod_top #(
  parameter int DATA_SIZE    = 16,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_I_IN,
  input  logic [CONTROL_SIZE-1:0] SIZE_J_IN,
  input  logic [DATA_SIZE-1:0]    MODULO_IN,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  input  logic                    DATA_IN_I_ENABLE,
  input  logic                    DATA_IN_J_ENABLE,
  output logic                    READY,
  output logic                    DATA_OUT_I_ENABLE,
  output logic                    DATA_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  // Controller and vector unit
  logic row_start;
  logic elem_enable;
  logic elem_done;
  logic row_ready;
  logic [DATA_SIZE-1:0] vec_data_out;

  ////////////////////
  // Row loop
  ////////////////////

  tensor_mod_ctrl #(
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_tensor_mod_ctrl (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_I_IN        (SIZE_I_IN),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .elem_done        (elem_done),
    .row_ready        (row_ready),
    .row_start        (row_start),
    .elem_enable      (elem_enable),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .READY            (READY)
  );

  ////////////////////
  // Row datapath
  ////////////////////

  // Row length is the J size
  vector_mod_unit #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_vector_mod_unit (
    .CLK        (CLK),
    .RST        (RST),
    .row_start  (row_start),
    .elem_enable(elem_enable),
    .SIZE_IN    (SIZE_J_IN),
    .MODULO_IN  (MODULO_IN),
    .DATA_IN    (DATA_IN),
    .elem_done  (elem_done),
    .row_ready  (row_ready),
    .DATA_OUT   (vec_data_out)
  );

  // Extra stage to match the controller's strobe register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT <= '0;
    end else if (elem_done) begin
      DATA_OUT <= vec_data_out;
    end
  end

endmodule

`default_nettype wire

// ==== logic/tensor_mod_ctrl.sv ====
/*
  Row-loop controller over SIZE_I rows
  Row starts, enable routing and tensor-level output strobes
*/

`timescale 1ns/100ps
`default_nettype none

module tensor_mod_ctrl
  import tensor_mod_pkg::*;
#(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_I_IN,
  input  logic                    DATA_IN_I_ENABLE,
  input  logic                    DATA_IN_J_ENABLE,
  input  logic                    elem_done,
  input  logic                    row_ready,
  output logic                    row_start,
  output logic                    elem_enable,
  output logic                    DATA_OUT_I_ENABLE,
  output logic                    DATA_OUT_J_ENABLE,
  output logic                    READY
);

  tensor_state_e state;

  // Row count and current row
  logic [CONTROL_SIZE-1:0] size_i_q;
  logic [CONTROL_SIZE-1:0] row_idx;
  logic last_row;

  // START taken only between tensors
  logic start_accept;

  assign last_row = (row_idx == size_i_q - CONTROL_SIZE'(1));

  assign start_accept = START &&
                        (state == tensor_idle || state == tensor_row_done);

  ////////////////////
  // Vector unit drive
  ////////////////////

  // Same cycle as START or the previous row's last result,
  // so the vector unit is waiting when the host sends the next element
  assign row_start = start_accept || (row_ready && !last_row);

  // I enable for column 0, J enable for the others
  always_comb begin
    case (state)
      tensor_start_row:  elem_enable = DATA_IN_I_ENABLE;
      tensor_stream_row: elem_enable = DATA_IN_J_ENABLE;
      default:           elem_enable = 1'b0;
    endcase
  end

  ////////////////////
  // Row loop
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= tensor_idle;
      size_i_q <= '0;
      row_idx  <= '0;
    end else begin
      case (state)
        tensor_idle, tensor_row_done: begin
          if (start_accept) begin
            size_i_q <= SIZE_I_IN;
            row_idx  <= '0;
            state    <= tensor_start_row;
          end else begin
            state <= tensor_idle;
          end
        end
        tensor_start_row, tensor_stream_row: begin
          if (row_ready) begin
            if (last_row) begin
              // READY shows during row done
              state <= tensor_row_done;
            end else begin
              row_idx <= row_idx + 1'b1;
              state   <= tensor_start_row;
            end
          end else if (elem_done) begin
            // First element of the row is back
            state <= tensor_stream_row;
          end
        end
        default: state <= tensor_idle;
      endcase
    end
  end

  ////////////////////
  // Output strobes
  ////////////////////

  // One register stage, all three line up with the same result
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      DATA_OUT_J_ENABLE <= elem_done;
      DATA_OUT_I_ENABLE <= row_ready;
      READY             <= row_ready && last_row;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vector_mod_unit.sv ====
/*
  Row vector unit, reduces SIZE_IN elements of one row
  Column counting around one scalar remainder core
*/

`timescale 1ns/100ps
`default_nettype none

module vector_mod_unit
  import tensor_mod_pkg::*;
#(
  parameter int DATA_SIZE    = 16,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    row_start,
  input  logic                    elem_enable,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0]    MODULO_IN,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  output logic                    elem_done,
  output logic                    row_ready,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  vector_state_e state;

  // Row length and column position
  logic [CONTROL_SIZE-1:0] size_q;
  logic [CONTROL_SIZE-1:0] col_idx;
  logic last_col;

  // Operands held for the core
  logic [DATA_SIZE-1:0] modulo_q;
  logic [DATA_SIZE-1:0] operand_q;

  // Core handshake
  logic core_start;
  logic core_done;
  logic [DATA_SIZE-1:0] remainder;

  assign last_col = (col_idx == size_q - CONTROL_SIZE'(1));

  ////////////////////
  // Row FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= vec_idle;
      size_q     <= '0;
      col_idx    <= '0;
      core_start <= 1'b0;
      elem_done  <= 1'b0;
      row_ready  <= 1'b0;
    end else begin
      core_start <= 1'b0;
      elem_done  <= 1'b0;
      row_ready  <= 1'b0;
      case (state)
        vec_idle: begin
          // First row of a tensor, sizes taken on the START cycle
          if (row_start) begin
            size_q  <= SIZE_IN;
            col_idx <= '0;
            state   <= vec_wait_elem;
          end
        end
        vec_wait_elem: begin
          if (elem_enable) begin
            core_start <= 1'b1;
            state      <= vec_reducing;
          end
        end
        vec_reducing: begin
          // Enables arriving here are dropped
          if (core_done) begin
            elem_done <= 1'b1;
            row_ready <= last_col;
            if (!last_col) begin
              col_idx <= col_idx + 1'b1;
            end
            state <= vec_emit;
          end
        end
        vec_emit: begin
          // Next row reuses the row length and modulus of this tensor
          if (row_start) begin
            col_idx <= '0;
            state   <= vec_wait_elem;
          end else if (row_ready) begin
            state <= vec_idle;
          end else begin
            state <= vec_wait_elem;
          end
        end
        default: state <= vec_idle;
      endcase
    end
  end

  // Operand capture and result register
  always_ff @(posedge CLK) begin
    if (state == vec_idle && row_start) begin
      modulo_q <= MODULO_IN;
    end
    if (state == vec_wait_elem && elem_enable) begin
      operand_q <= DATA_IN;
    end
    if (state == vec_reducing && core_done) begin
      DATA_OUT <= remainder;
    end
  end

  ////////////////////
  // Scalar core
  ////////////////////

  scalar_mod_core #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_mod_core (
    .CLK       (CLK),
    .RST       (RST),
    .core_start(core_start),
    .operand   (operand_q),
    .modulus   (modulo_q),
    .core_done (core_done),
    .remainder (remainder)
  );

endmodule

`default_nettype wire

// ==== logic/scalar_mod_core.sv ====
/*
  Iterative restoring remainder of one unsigned element
  One quotient bit per cycle, quotient discarded
*/

`timescale 1ns/100ps
`default_nettype none

module scalar_mod_core
  import tensor_mod_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 core_start,
  input  logic [DATA_SIZE-1:0] operand,
  input  logic [DATA_SIZE-1:0] modulus,
  output logic                 core_done,
  output logic [DATA_SIZE-1:0] remainder
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  core_state_e state;
  logic [CNT_W-1:0] bit_cnt;
  logic last_bit;

  // Operand bits still to be shifted in, MSB first
  logic [DATA_SIZE-1:0] dividend_q;
  // Running partial remainder, always below the modulus after a step
  logic [DATA_SIZE-1:0] partial_q;

  // One extra bit, the shifted partial can exceed DATA_SIZE bits
  logic [DATA_SIZE:0] trial;
  logic [DATA_SIZE:0] diff;
  logic [DATA_SIZE-1:0] next_partial;

  assign last_bit = (bit_cnt == CNT_W'(DATA_SIZE - 1));

  ////////////////////
  // Datapath step
  ////////////////////

  always_comb begin
    trial = {partial_q, dividend_q[DATA_SIZE-1]};
    diff  = trial - {1'b0, modulus};
    // Subtract when not smaller; modulus 0 always subtracts nothing
    if (trial >= {1'b0, modulus}) begin
      next_partial = diff[DATA_SIZE-1:0];
    end else begin
      next_partial = trial[DATA_SIZE-1:0];
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= core_idle;
      bit_cnt   <= '0;
      core_done <= 1'b0;
    end else begin
      core_done <= 1'b0;
      case (state)
        core_idle: begin
          if (core_start) begin
            bit_cnt <= '0;
            state   <= core_shifting;
          end
        end
        core_shifting: begin
          bit_cnt <= bit_cnt + 1'b1;
          // Done strobe lands DATA_SIZE+1 cycles after core_start
          if (last_bit) begin
            core_done <= 1'b1;
            state     <= core_idle;
          end
        end
        default: state <= core_idle;
      endcase
    end
  end

  // Shift registers and result
  always_ff @(posedge CLK) begin
    if (state == core_idle && core_start) begin
      dividend_q <= operand;
      partial_q  <= '0;
    end else if (state == core_shifting) begin
      dividend_q <= dividend_q << 1;
      partial_q  <= next_partial;
      if (last_bit) begin
        remainder <= next_partial;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/tensor_mod_pkg.sv ====
/*
  Shared FSM state types for the tensor modulo subsystem:
  row-loop controller, row vector unit and scalar remainder core
*/

`default_nettype none

package tensor_mod_pkg;

  ////////////////////
  // Row-loop controller
  ////////////////////

  // Start row waits for the first element, stream row for the rest
  typedef enum logic [1:0] {
    tensor_idle       = 2'd0,
    tensor_start_row  = 2'd1,
    tensor_stream_row = 2'd2,
    tensor_row_done   = 2'd3
  } tensor_state_e;

  ////////////////////
  // Row vector unit
  ////////////////////

  typedef enum logic [1:0] {
    vec_idle      = 2'd0,
    vec_wait_elem = 2'd1,
    vec_reducing  = 2'd2,
    vec_emit      = 2'd3
  } vector_state_e;

  ////////////////////
  // Scalar remainder core
  ////////////////////

  typedef enum logic [0:0] {
    core_idle     = 1'b0,
    core_shifting = 1'b1
  } core_state_e;

endpackage

`default_nettype wire
